//--- design/itim_pkg.sv
package itim_pkg;

  // Instruction or data word on every bus.
  typedef logic [31:0] word_t;

  // Byte address; bits 1:0 are always zero on the word buses.
  typedef logic [31:0] addr_t;

  // Request side of the fetch, data, refill and memory buses.
  typedef struct packed {
    logic  valid;
    logic  fence;
    logic  wen;
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  // Response side. Ready is a one-cycle pulse.
  typedef struct packed {
    logic  ready;
    word_t rdata;
  } mem_rsp_t;

  // ITIM controller back-end states.
  typedef enum logic [2:0] {
    st_hit,
    st_miss,
    st_load,
    st_update,
    st_fence
  } itim_state_t;

endpackage

//--- design/itim_ram.sv
`timescale 1ns/1ps

module itim_ram #(
  parameter int data_bits = 32,
  parameter int addr_bits = 3
) (
  input  logic                 clk,
  input  logic                 wen,
  input  logic [addr_bits-1:0] waddr,
  input  logic [data_bits-1:0] wdata,
  input  logic [addr_bits-1:0] raddr,
  output logic [data_bits-1:0] rdata
);

  logic [data_bits-1:0] mem [2**addr_bits];

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];  // Read data follows the address by one cycle.
  end

endmodule

//--- design/itim_ctrl.sv
`timescale 1ns/1ps

module itim_ctrl #(
  parameter int              itim_depth = 3,
  parameter int              itim_width = 2,
  parameter itim_pkg::addr_t itim_base  = 32'h0000_0000,
  parameter itim_pkg::addr_t itim_top   = 32'h0000_0400
) (
  input  logic                               clk,
  input  logic                               rst,
  input  itim_pkg::mem_req_t                 fetch_req,
  output itim_pkg::mem_rsp_t                 fetch_rsp,
  output itim_pkg::mem_req_t                 refill_req,
  input  itim_pkg::mem_rsp_t                 refill_rsp,
  output logic                               tag_wen,
  output logic [itim_depth-1:0]              tag_waddr,
  output logic [29-itim_depth-itim_width:0]  tag_wdata,
  output logic [itim_depth-1:0]              tag_raddr,
  input  logic [29-itim_depth-itim_width:0]  tag_rdata,
  output logic                               data_wen,
  output logic [itim_depth-1:0]              data_waddr,
  output logic [32*(2**itim_width)-1:0]      data_wdata,
  output logic [itim_depth-1:0]              data_raddr,
  input  logic [32*(2**itim_width)-1:0]      data_rdata,
  output logic                               lock_wen,
  output logic [itim_depth-1:0]              lock_waddr,
  output logic                               lock_wdata,
  output logic [itim_depth-1:0]              lock_raddr,
  input  logic                               lock_rdata
);

  localparam int tag_bits   = 30 - itim_depth - itim_width;
  localparam int line_words = 2 ** itim_width;
  localparam int line_bits  = 32 * line_words;

  typedef logic [tag_bits-1:0]   tag_t;
  typedef logic [itim_depth-1:0] idx_t;
  typedef logic [itim_width-1:0] off_t;
  typedef logic [line_bits-1:0]  line_t;

  typedef struct packed {
    logic            valid;
    logic            fence;
    itim_pkg::addr_t addr;
    tag_t            tag;
    idx_t            idx;
    off_t            off;
  } front_t;

  front_t                f_q;
  itim_pkg::itim_state_t state_q;
  off_t                  cnt_q;
  idx_t                  sweep_q;
  itim_pkg::addr_t       fill_addr_q;
  line_t                 line_q;
  idx_t                  req_idx;
  logic                  in_window;
  logic                  lookup_hit;
  logic                  sweep_last;

  // The arrays are read with the index being captured, so their data lines up with f_q.
  assign req_idx    = fetch_req.addr[itim_width+itim_depth+1:itim_width+2];
  assign in_window  = (f_q.addr >= itim_base) && (f_q.addr < itim_top);
  assign lookup_hit = lock_rdata && (tag_rdata == f_q.tag);
  assign sweep_last = (sweep_q == idx_t'(2**itim_depth - 1));

  always_ff @(posedge clk) begin
    if (!rst) begin
      f_q.valid <= 1'b0;
      f_q.fence <= 1'b0;
    end else begin
      f_q.valid <= fetch_req.valid & ~fetch_req.fence;
      f_q.fence <= fetch_req.valid & fetch_req.fence;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_req.valid && !fetch_req.fence) begin
      f_q.addr <= fetch_req.addr;
      f_q.tag  <= fetch_req.addr[31:itim_width+itim_depth+2];
      f_q.idx  <= req_idx;
      f_q.off  <= fetch_req.addr[itim_width+1:2];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state_q <= itim_pkg::st_hit;
      cnt_q   <= '0;
      sweep_q <= '0;
    end else begin
      case (state_q)
        itim_pkg::st_hit: begin
          if (f_q.fence) begin
            state_q <= itim_pkg::st_fence;
            sweep_q <= '0;
          end else if (f_q.valid && !in_window) begin
            state_q <= itim_pkg::st_load;
          end else if (f_q.valid && !lookup_hit) begin
            state_q <= itim_pkg::st_miss;  // A tag mismatch evicts the line.
            cnt_q   <= '0;
          end
        end
        itim_pkg::st_miss: begin
          if (refill_rsp.ready) begin
            if (cnt_q == off_t'(line_words - 1)) begin
              state_q <= itim_pkg::st_update;
            end
            cnt_q <= cnt_q + 1'b1;
          end
        end
        itim_pkg::st_load: begin
          if (refill_rsp.ready) begin
            state_q <= itim_pkg::st_hit;
          end
        end
        itim_pkg::st_update: begin
          state_q <= itim_pkg::st_hit;
        end
        itim_pkg::st_fence: begin
          if (sweep_last) begin
            state_q <= itim_pkg::st_hit;
          end
          sweep_q <= sweep_q + 1'b1;
        end
        default: begin
          state_q <= itim_pkg::st_hit;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == itim_pkg::st_hit) begin
      if (in_window) begin
        fill_addr_q <= {f_q.tag, f_q.idx, {(itim_width+2){1'b0}}};
      end else begin
        fill_addr_q <= f_q.addr;
      end
    end else if (state_q == itim_pkg::st_miss && refill_rsp.ready) begin
      fill_addr_q            <= fill_addr_q + 32'd4;
      line_q[32*cnt_q +: 32] <= refill_rsp.rdata;
    end
  end

  always_comb begin
    refill_req.valid = (state_q == itim_pkg::st_miss) || (state_q == itim_pkg::st_load);
    refill_req.fence = 1'b0;
    refill_req.wen   = 1'b0;
    refill_req.addr  = fill_addr_q;
    refill_req.wdata = '0;
  end

  always_comb begin
    fetch_rsp.ready = 1'b0;
    fetch_rsp.rdata = '0;
    case (state_q)
      itim_pkg::st_hit: begin
        fetch_rsp.ready = f_q.valid & in_window & lookup_hit;
        fetch_rsp.rdata = data_rdata[32*f_q.off +: 32];
      end
      itim_pkg::st_load: begin
        fetch_rsp.ready = refill_rsp.ready;
        fetch_rsp.rdata = refill_rsp.rdata;
      end
      itim_pkg::st_update: begin
        fetch_rsp.ready = 1'b1;
        fetch_rsp.rdata = line_q[32*f_q.off +: 32];
      end
      itim_pkg::st_fence: begin
        fetch_rsp.ready = sweep_last;  // Rdata stays zero for a fence.
      end
      default: begin
        fetch_rsp.ready = 1'b0;
      end
    endcase
  end

  assign tag_raddr  = req_idx;
  assign data_raddr = req_idx;
  assign lock_raddr = req_idx;

  assign tag_wen    = (state_q == itim_pkg::st_update);
  assign tag_waddr  = f_q.idx;
  assign tag_wdata  = f_q.tag;
  assign data_wen   = (state_q == itim_pkg::st_update);
  assign data_waddr = f_q.idx;
  assign data_wdata = line_q;

  // The lock bit doubles as line valid. Fence sweeps it to zero.
  assign lock_wen   = (state_q == itim_pkg::st_update) || (state_q == itim_pkg::st_fence);
  assign lock_waddr = (state_q == itim_pkg::st_fence) ? sweep_q : f_q.idx;
  assign lock_wdata = (state_q == itim_pkg::st_update);

endmodule

//--- design/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
  input  logic               clk,
  input  logic               rst,
  input  itim_pkg::mem_req_t itim_req,
  input  itim_pkg::mem_req_t data_req,
  output itim_pkg::mem_rsp_t itim_rsp,
  output itim_pkg::mem_rsp_t data_rsp,
  output itim_pkg::mem_req_t mem_req,
  input  itim_pkg::mem_rsp_t mem_rsp
);

  itim_pkg::mem_req_t data_q;
  itim_pkg::mem_req_t data_cur;
  logic               data_pend_q;
  logic               busy_q;
  logic               own_data_q;
  logic               sel_data;

  // The data port pulses once. The held copy keeps the level up until ready.
  assign data_cur = data_pend_q ? data_q : data_req;
  assign sel_data = busy_q ? own_data_q : data_cur.valid;

  always_comb begin
    mem_req        = sel_data ? data_cur : itim_req;
    itim_rsp.ready = mem_rsp.ready & ~sel_data;
    itim_rsp.rdata = mem_rsp.rdata;
    data_rsp.ready = mem_rsp.ready & sel_data;
    data_rsp.rdata = mem_rsp.rdata;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      busy_q      <= 1'b0;
      own_data_q  <= 1'b0;
      data_pend_q <= 1'b0;
    end else begin
      if (mem_rsp.ready) begin
        busy_q <= 1'b0;
      end else if (!busy_q && mem_req.valid) begin
        busy_q     <= 1'b1;  // Grant holds until the memory answers.
        own_data_q <= sel_data;
      end
      if (data_rsp.ready) begin
        data_pend_q <= 1'b0;
      end else if (data_req.valid) begin
        data_pend_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (data_req.valid) begin
      data_q <= data_req;
    end
  end

endmodule

//--- design/backing_mem.sv
`timescale 1ns/1ps

module backing_mem #(
  parameter int mem_words   = 1024,
  parameter int mem_latency = 2
) (
  input  logic               clk,
  input  logic               rst,
  input  itim_pkg::mem_req_t mem_req,
  output itim_pkg::mem_rsp_t mem_rsp
);

  localparam int idx_bits = $clog2(mem_words);
  localparam int cnt_bits = $clog2(mem_latency) + 1;

  typedef logic [idx_bits-1:0] widx_t;

  itim_pkg::word_t      mem [mem_words];
  itim_pkg::word_t      rdata_q;
  logic                 ready_q;
  logic [cnt_bits-1:0]  cnt_q;
  widx_t                widx;
  logic                 fire;

  assign widx = mem_req.addr[idx_bits+1:2];
  assign fire = mem_req.valid && !ready_q && (cnt_q == cnt_bits'(mem_latency - 1));

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q <= 1'b0;
      cnt_q   <= '0;
    end else if (ready_q) begin
      ready_q <= 1'b0;  // Valid seen after a ready belongs to a new transfer.
      cnt_q   <= '0;
    end else if (fire) begin
      ready_q <= 1'b1;
      cnt_q   <= '0;
    end else if (mem_req.valid) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      if (mem_req.wen) begin
        mem[widx] <= mem_req.wdata;
      end
      rdata_q <= mem[widx];
    end
  end

  assign mem_rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

//--- design/itim_subsys.sv
`timescale 1ns/1ps

module itim_subsys #(
  parameter int              itim_depth  = 3,
  parameter int              itim_width  = 2,
  parameter itim_pkg::addr_t itim_base   = 32'h0000_0000,
  parameter itim_pkg::addr_t itim_top    = 32'h0000_0400,
  parameter int              mem_words   = 1024,
  parameter int              mem_latency = 2
) (
  input  logic               clk,
  input  logic               rst,
  input  itim_pkg::mem_req_t fetch_req,
  output itim_pkg::mem_rsp_t fetch_rsp,
  input  itim_pkg::mem_req_t data_req,
  output itim_pkg::mem_rsp_t data_rsp
);

  localparam int tag_bits  = 30 - itim_depth - itim_width;
  localparam int line_bits = 32 * (2 ** itim_width);

  itim_pkg::mem_req_t    refill_req;
  itim_pkg::mem_rsp_t    refill_rsp;
  itim_pkg::mem_req_t    mem_req;
  itim_pkg::mem_rsp_t    mem_rsp;

  logic                  tag_wen;
  logic [itim_depth-1:0] tag_waddr;
  logic [tag_bits-1:0]   tag_wdata;
  logic [itim_depth-1:0] tag_raddr;
  logic [tag_bits-1:0]   tag_rdata;
  logic                  data_wen;
  logic [itim_depth-1:0] data_waddr;
  logic [line_bits-1:0]  data_wdata;
  logic [itim_depth-1:0] data_raddr;
  logic [line_bits-1:0]  data_rdata;
  logic                  lock_wen;
  logic [itim_depth-1:0] lock_waddr;
  logic                  lock_wdata;
  logic [itim_depth-1:0] lock_raddr;
  logic                  lock_rdata;

  itim_ctrl #(
    .itim_depth (itim_depth),
    .itim_width (itim_width),
    .itim_base  (itim_base),
    .itim_top   (itim_top)
  ) itim_ctrl_i (.*);

  itim_ram #(
    .data_bits (tag_bits),
    .addr_bits (itim_depth)
  ) tag_ram_i (
    .clk   (clk),
    .wen   (tag_wen),
    .waddr (tag_waddr),
    .wdata (tag_wdata),
    .raddr (tag_raddr),
    .rdata (tag_rdata)
  );

  itim_ram #(
    .data_bits (line_bits),
    .addr_bits (itim_depth)
  ) data_ram_i (
    .clk   (clk),
    .wen   (data_wen),
    .waddr (data_waddr),
    .wdata (data_wdata),
    .raddr (data_raddr),
    .rdata (data_rdata)
  );

  itim_ram #(
    .data_bits (1),
    .addr_bits (itim_depth)
  ) lock_ram_i (
    .clk   (clk),
    .wen   (lock_wen),
    .waddr (lock_waddr),
    .wdata (lock_wdata),
    .raddr (lock_raddr),
    .rdata (lock_rdata)
  );

  mem_arbiter mem_arbiter_i (
    .clk      (clk),
    .rst      (rst),
    .itim_req (refill_req),
    .data_req (data_req),
    .itim_rsp (refill_rsp),
    .data_rsp (data_rsp),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp)
  );

  backing_mem #(
    .mem_words   (mem_words),
    .mem_latency (mem_latency)
  ) backing_mem_i (
    .clk     (clk),
    .rst     (rst),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int half_period  = 4,
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  initial begin
    rst = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b1;  // Released just after an edge, like every other input.
  end

endmodule

//--- sim/itim_subsys_props.sv
`timescale 1ns/1ps

module itim_subsys_props (
  input logic               clk,
  input logic               rst,
  input itim_pkg::mem_req_t fetch_req,
  input itim_pkg::mem_rsp_t fetch_rsp,
  input itim_pkg::mem_req_t refill_req,
  input itim_pkg::mem_rsp_t refill_rsp,
  input itim_pkg::mem_req_t data_req,
  input itim_pkg::mem_rsp_t data_rsp
);

  logic open_q;
  logic data_open_q;

  always_ff @(posedge clk) begin
    if (!rst) begin
      open_q <= 1'b0;
    end else if (fetch_req.valid) begin
      open_q <= 1'b1;  // A fetch or fence is outstanding.
    end else if (fetch_rsp.ready) begin
      open_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      data_open_q <= 1'b0;
    end else if (data_req.valid) begin
      data_open_q <= 1'b1;  // A data-port access waits for its reply.
    end else if (data_rsp.ready) begin
      data_open_q <= 1'b0;
    end
  end

  refill_held: assert property (@(posedge clk) disable iff (!rst)
    refill_req.valid && !refill_rsp.ready |=> refill_req.valid && $stable(refill_req.addr))
    else $error("refill request dropped or moved before ready");

  fetch_ready_open: assert property (@(posedge clk) disable iff (!rst)
    fetch_rsp.ready |-> open_q)
    else $error("fetch ready without an open request");

  itim_ready_routed: assert property (@(posedge clk) disable iff (!rst)
    refill_rsp.ready |-> refill_req.valid)
    else $error("arbiter returned ready to the idle refill port");

  data_ready_routed: assert property (@(posedge clk) disable iff (!rst)
    data_rsp.ready |-> data_open_q)
    else $error("arbiter returned ready to the idle data port");

endmodule

// The fetch, refill and data buses all meet in the top level.
bind itim_subsys itim_subsys_props props_i (
  .clk        (clk),
  .rst        (rst),
  .fetch_req  (fetch_req),
  .fetch_rsp  (fetch_rsp),
  .refill_req (refill_req),
  .refill_rsp (refill_rsp),
  .data_req   (data_req),
  .data_rsp   (data_rsp)
);

//--- sim/itim_subsys_tb.sv
`timescale 1ns/1ps

module itim_subsys_tb;

  localparam int              itim_depth    = 3;
  localparam int              itim_width    = 2;
  localparam itim_pkg::addr_t itim_base     = 32'h0000_0000;
  localparam itim_pkg::addr_t itim_top      = 32'h0000_0400;
  localparam int              mem_words     = 1024;
  localparam int              mem_latency   = 2;
  localparam int              cycles_per_op =
    (2 ** itim_width) * (mem_latency + 2) + 2 ** itim_depth + 10;

  typedef struct packed {
    logic [7:0]      op;
    itim_pkg::addr_t addr;
    itim_pkg::word_t value;
    logic            hit;
  } vector_t;

  logic               clk;
  logic               rst;
  itim_pkg::mem_req_t fetch_req;
  itim_pkg::mem_rsp_t fetch_rsp;
  itim_pkg::mem_req_t data_req;
  itim_pkg::mem_rsp_t data_rsp;
  vector_t            vectors[$];
  int                 cycle_count = 0;
  int                 cycle_limit = 0;

  tb_clock clock_i (
    .clk (clk),
    .rst (rst)
  );

  itim_subsys #(
    .itim_depth  (itim_depth),
    .itim_width  (itim_width),
    .itim_base   (itim_base),
    .itim_top    (itim_top),
    .mem_words   (mem_words),
    .mem_latency (mem_latency)
  ) itim_subsys_i (
    .clk       (clk),
    .rst       (rst),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .data_req  (data_req),
    .data_rsp  (data_rsp)
  );

  task automatic stop_with_failure();
    $display("TEST FAILED");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t %s actual=%h expected=%h", $time, name, actual, expected);
      stop_with_failure();
    end
  endtask

  task automatic read_vectors();
    int              fd;
    int              code;
    int              c;
    int              hit;
    logic [7:0]      op;
    itim_pkg::addr_t addr;
    itim_pkg::word_t value;
    fd = $fopen("sim/itim_vectors.txt", "r");
    if (fd == 0) begin
      $display("The vector file sim/itim_vectors.txt could not be opened.");
      stop_with_failure();
    end
    code = $fscanf(fd, "%s", op);
    while (code == 1) begin
      if (op == "#") begin
        c = $fgetc(fd);
        while (c != "\n" && c != -1) c = $fgetc(fd);  // Skip the rest of a comment line.
      end else begin
        code = $fscanf(fd, "%h %h %d", addr, value, hit);
        if (code != 3) begin
          $display("A vector line after entry %0d is malformed.", vectors.size());
          stop_with_failure();
        end
        vectors.push_back('{op: op, addr: addr, value: value, hit: hit[0]});
      end
      code = $fscanf(fd, "%s", op);
    end
    $fclose(fd);
    if (vectors.size() == 0) begin
      $display("The vector file holds no operations.");
      stop_with_failure();
    end
  endtask

  task automatic pulse_fetch(input itim_pkg::addr_t addr, input logic fence);
    @(posedge clk);
    #1;
    fetch_req = '{valid: 1'b1, fence: fence, wen: 1'b0, addr: addr, wdata: '0};
    @(posedge clk);
    #1;
    fetch_req.valid = 1'b0;
    fetch_req.fence = 1'b0;
  endtask

  task automatic pulse_data(input itim_pkg::addr_t addr, input logic wen,
                            input itim_pkg::word_t wdata);
    @(posedge clk);
    #1;
    data_req = '{valid: 1'b1, fence: 1'b0, wen: wen, addr: addr, wdata: wdata};
    @(posedge clk);
    #1;
    data_req.valid = 1'b0;
  endtask

  // Counts cycles after the request edge, so a hit reports exactly one.
  task automatic wait_ready(input logic on_data, output itim_pkg::word_t rdata,
                            output int cycles);
    logic seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen) begin
      @(negedge clk);
      cycles = cycles + 1;
      seen   = on_data ? data_rsp.ready : fetch_rsp.ready;
    end
    rdata = on_data ? data_rsp.rdata : fetch_rsp.rdata;
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the vectors did not finish within %0d cycles.", cycle_limit);
      stop_with_failure();
    end
  end

  initial begin
    itim_pkg::word_t rdata;
    int              cycles;
    vector_t         v;
    fetch_req = '0;
    data_req  = '0;
    read_vectors();
    cycle_limit = vectors.size() * cycles_per_op;
    wait (rst === 1'b1);
    foreach (vectors[i]) begin
      v = vectors[i];
      case (v.op)
        "W": begin
          pulse_data(v.addr, 1'b1, v.value);
          wait_ready(1'b1, rdata, cycles);
        end
        "R": begin
          pulse_data(v.addr, 1'b0, '0);
          wait_ready(1'b1, rdata, cycles);
          check_value("data_rsp.rdata", rdata, v.value);
        end
        "F": begin
          pulse_fetch(v.addr, 1'b0);
          wait_ready(1'b0, rdata, cycles);
          check_value("fetch_rsp.rdata", rdata, v.value);
          check_value("fetch one-cycle hit", {31'd0, cycles == 1}, {31'd0, v.hit});
        end
        "X": begin
          pulse_fetch('0, 1'b1);
          wait_ready(1'b0, rdata, cycles);
          check_value("fence fetch_rsp.rdata", rdata, v.value);
        end
        default: begin
          $display("Vector %0d has an unknown operation code.", i);
          stop_with_failure();
        end
      endcase
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- sim/itim_vectors.txt
# op addr value hit : op is W data write, R data read, F fetch, X fence
# value is write data for W and expected data otherwise; hit 1 means a one-cycle fetch
W 00000100 11111111 0
W 00000100 22222222 0
R 00000100 22222222 0
W 00000040 13000001 0
W 00000044 13000002 0
W 00000048 13000003 0
W 0000004c 13000004 0
X 00000000 00000000 0
F 00000040 13000001 0
F 00000048 13000003 1
W 00000044 a5a5a5a5 0
R 00000044 a5a5a5a5 0
F 00000044 13000002 1
X 00000000 00000000 0
F 00000044 a5a5a5a5 0
F 00000040 13000001 1
W 000000c0 6f000010 0
F 000000c0 6f000010 0
F 000000c0 6f000010 1
F 00000040 13000001 0
F 00000044 a5a5a5a5 1
F 000000c0 6f000010 0
W 00000400 deadbeef 0
F 00000400 deadbeef 0
F 00000400 deadbeef 0
X 00000000 00000000 0

//--- list.f
design/itim_pkg.sv
design/itim_ram.sv
design/itim_ctrl.sv
design/mem_arbiter.sv
design/backing_mem.sv
design/itim_subsys.sv
sim/tb_clock.sv
sim/itim_subsys_props.sv
sim/itim_subsys_tb.sv
